//--- hw/scrollPkg.sv
// ==========================================================
// Shared widths, character types and the converter states
// Input is limited to 34 bits and the display to ten digits
// ASCII space is the blank character and lights no segment
// ==========================================================

package scrollPkg;

    // Binary input width, enough for 9,999,999,999
    localparam int NumberWidth = 34;

    // Decimal digits handled by the converter and the ring
    localparam int MaxDigits = 10;

    // Ring holds every digit plus one blank separator
    localparam int RingLen = MaxDigits + 1;

    // Number of physical display positions
    localparam int WindowLen = 4;

    typedef logic [7:0] asciiChar;

    // Packed 4-bit digits, digit 0 is the least significant
    typedef logic [MaxDigits*4-1:0] bcdDigits;

    localparam asciiChar BlankChar = 8'h20;

    // States of the sequential double-dabble converter
    typedef enum logic [1:0] {
        idle,
        shifting,
        finished
    } converterState;

endpackage

//--- hw/binToBcd.sv
// ==========================================================
// Sequential double-dabble converter, one bit per cycle
// convDone comes NumberWidth+1 cycles after an accepted start
// start is ignored while busy; inputs above 9,999,999,999
// set overflow and the digits are then meaningless
// ==========================================================

`timescale 1ns/1ps

module binToBcd (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  logic [scrollPkg::NumberWidth-1:0] number,
    output scrollPkg::bcdDigits               digits,
    output logic                              overflow,
    output logic                              convDone,
    output logic                              busy
);

    localparam int CountWidth = $clog2(scrollPkg::NumberWidth);
    localparam int BcdWidth = scrollPkg::MaxDigits * 4;

    // Largest value that still fits in ten decimal digits
    localparam logic [scrollPkg::NumberWidth-1:0] MaxValue =
        scrollPkg::NumberWidth'(64'd9_999_999_999);

    scrollPkg::converterState state;

    logic [scrollPkg::NumberWidth-1:0] binReg;
    logic [CountWidth-1:0]             shiftCount;
    scrollPkg::bcdDigits               adjusted;

    // Add three to every digit of five or more before the shift
    always_comb begin
        for (int i = 0; i < scrollPkg::MaxDigits; i++) begin
            if (digits[i*4 +: 4] > 4'd4) begin
                adjusted[i*4 +: 4] = digits[i*4 +: 4] + 4'd3;
            end else begin
                adjusted[i*4 +: 4] = digits[i*4 +: 4];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= scrollPkg::idle;
            shiftCount <= '0;
        end else begin
            case (state)
                scrollPkg::idle: begin
                    if (start) begin
                        state      <= scrollPkg::shifting;
                        shiftCount <= '0;
                    end
                end
                scrollPkg::shifting: begin
                    // Last of NumberWidth shifts
                    if (shiftCount == CountWidth'(scrollPkg::NumberWidth - 1)) begin
                        state <= scrollPkg::finished;
                    end
                    shiftCount <= shiftCount + 1'b1;
                end
                scrollPkg::finished: begin
                    state <= scrollPkg::idle;
                end
                default: begin
                    state <= scrollPkg::idle;
                end
            endcase
        end
    end

    // Shift register pair, digits hold their value until the next start
    always_ff @(posedge clk) begin
        if (state == scrollPkg::idle && start) begin
            binReg   <= number;
            digits   <= '0;
            overflow <= (number > MaxValue);
        end else if (state == scrollPkg::shifting) begin
            digits <= {adjusted[BcdWidth-2:0], binReg[scrollPkg::NumberWidth-1]};
            binReg <= binReg << 1;
        end
    end

    assign convDone = (state == scrollPkg::finished);

    // High through the convDone cycle, so ready returns one cycle later
    assign busy = (state != scrollPkg::idle);

endmodule

//--- hw/scrollBuffer.sv
// ==========================================================
// Character ring built from the converted digits
// Up to four significant digits are shown right-aligned and
// do not move; longer numbers rotate left every DWELL_FRAMES
// frames through the digits and one blank separator
// ==========================================================

`timescale 1ns/1ps

module scrollBuffer #(
    parameter int DWELL_FRAMES = 2
) (
    input  logic                clk,
    input  logic                reset,
    input  scrollPkg::bcdDigits digits,
    input  logic                overflow,
    input  logic                convDone,
    input  logic                frameEnd,
    output logic                loaded,
    output scrollPkg::asciiChar window0,
    output scrollPkg::asciiChar window1,
    output scrollPkg::asciiChar window2,
    output scrollPkg::asciiChar window3
);

    localparam int PtrWidth = $clog2(scrollPkg::RingLen + 1);
    localparam int DwellWidth = $clog2(DWELL_FRAMES + 1);

    scrollPkg::asciiChar ring     [scrollPkg::RingLen];
    scrollPkg::asciiChar nextRing [scrollPkg::RingLen];

    logic [PtrWidth-1:0]   ringLen;
    logic [PtrWidth-1:0]   nextLen;
    logic [PtrWidth-1:0]   startPtr;
    logic [DwellWidth-1:0] frameCount;
    logic [PtrWidth-1:0]   slotIdx [scrollPkg::WindowLen];

    function automatic scrollPkg::asciiChar digitChar(input logic [3:0] d);
        return {4'h3, d};
    endfunction

    // New ring contents, taken only in the convDone cycle
    always_comb begin
        int sigCount;

        // At least one digit so that zero shows "0"
        sigCount = 1;
        for (int i = 1; i < scrollPkg::MaxDigits; i++) begin
            if (digits[i*4 +: 4] != 4'd0) begin
                sigCount = i + 1;
            end
        end

        for (int i = 0; i < scrollPkg::RingLen; i++) begin
            nextRing[i] = scrollPkg::BlankChar;
        end
        nextLen = PtrWidth'(scrollPkg::WindowLen);

        if (overflow) begin
            nextRing[1] = "E";
            nextRing[2] = "r";
            nextRing[3] = "r";
        end else if (sigCount <= scrollPkg::WindowLen) begin
            // Static, right-aligned with leading blanks
            for (int i = 0; i < scrollPkg::WindowLen; i++) begin
                if (scrollPkg::WindowLen - 1 - i < sigCount) begin
                    nextRing[i] = digitChar(digits[(scrollPkg::WindowLen - 1 - i)*4 +: 4]);
                end
            end
        end else begin
            // Most significant digit first, blank separator follows
            for (int i = 0; i < scrollPkg::MaxDigits; i++) begin
                if (i < sigCount) begin
                    nextRing[i] = digitChar(digits[(sigCount - 1 - i)*4 +: 4]);
                end
            end
            nextLen = PtrWidth'(sigCount + 1);
        end
    end

    always_ff @(posedge clk) begin
        if (convDone) begin
            ring <= nextRing;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ringLen    <= PtrWidth'(scrollPkg::WindowLen);
            startPtr   <= '0;
            frameCount <= '0;
            loaded     <= 1'b0;
        end else if (convDone) begin
            // A new number always restarts at the ring start
            ringLen    <= nextLen;
            startPtr   <= '0;
            frameCount <= '0;
            loaded     <= 1'b1;
        end else if (frameEnd) begin
            if (frameCount == DwellWidth'(DWELL_FRAMES - 1)) begin
                frameCount <= '0;
                if (ringLen > PtrWidth'(scrollPkg::WindowLen)) begin
                    startPtr <= (startPtr == ringLen - 1'b1) ? '0 : startPtr + 1'b1;
                end
            end else begin
                frameCount <= frameCount + 1'b1;
            end
        end
    end

    // Window slots modulo the ring length, startPtr is always below ringLen
    always_comb begin
        for (int k = 0; k < scrollPkg::WindowLen; k++) begin
            if (startPtr + PtrWidth'(k) >= ringLen) begin
                slotIdx[k] = startPtr + PtrWidth'(k) - ringLen;
            end else begin
                slotIdx[k] = startPtr + PtrWidth'(k);
            end
        end
    end

    assign window3 = ring[slotIdx[0]];
    assign window2 = ring[slotIdx[1]];
    assign window1 = ring[slotIdx[2]];
    assign window0 = ring[slotIdx[3]];

endmodule

//--- hw/segmentDriver.sv
// ==========================================================
// Four-digit multiplexed seven-segment driver, active low
// seg bit 6 is segment a and bit 0 is segment g
// Each digit is lit for REFRESH_CYCLES cycles, leftmost first
// Only 0-9, E, r and space have glyphs; others show blank
// ==========================================================

`timescale 1ns/1ps

module segmentDriver #(
    parameter int REFRESH_CYCLES = 50_000
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  scrollPkg::asciiChar window0,
    input  scrollPkg::asciiChar window1,
    input  scrollPkg::asciiChar window2,
    input  scrollPkg::asciiChar window3,
    output logic [6:0]          seg,
    output logic [3:0]          an,
    output logic                frameEnd
);

    localparam int RefreshWidth = $clog2(REFRESH_CYCLES + 1);

    logic [RefreshWidth-1:0] refreshCount;
    logic [1:0]              digitIdx;
    logic                    slotEnd;
    scrollPkg::asciiChar     slotChar;

    // Patterns listed a to g, a zero lights the segment
    function automatic logic [6:0] charToSeg(input scrollPkg::asciiChar c);
        case (c)
            "0":     return 7'b0000001;
            "1":     return 7'b1001111;
            "2":     return 7'b0010010;
            "3":     return 7'b0000110;
            "4":     return 7'b1001100;
            "5":     return 7'b0100100;
            "6":     return 7'b0100000;
            "7":     return 7'b0001111;
            "8":     return 7'b0000000;
            "9":     return 7'b0000100;
            "E":     return 7'b0110000;
            "r":     return 7'b1111010;
            " ":     return 7'b1111111;
            default: return 7'b1111111;
        endcase
    endfunction

    assign slotEnd = (refreshCount == RefreshWidth'(REFRESH_CYCLES - 1));

    always_comb begin
        case (digitIdx)
            2'd3:    slotChar = window3;
            2'd2:    slotChar = window2;
            2'd1:    slotChar = window1;
            default: slotChar = window0;
        endcase
    end

    // Last counter cycle of digit 0; counters sit at digit 3 while disabled.
    // The window may then change before digit 3 is sampled again
    assign frameEnd = slotEnd && (digitIdx == 2'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            refreshCount <= '0;
            digitIdx     <= 2'd3;
            seg          <= '1;
            an           <= '1;
        end else if (!enable) begin
            refreshCount <= '0;
            digitIdx     <= 2'd3;
            seg          <= '1;
            an           <= '1;
        end else begin
            seg <= charToSeg(slotChar);
            an  <= ~(4'b0001 << digitIdx);
            if (slotEnd) begin
                refreshCount <= '0;
                // Wraps from digit 0 back to digit 3
                digitIdx     <= digitIdx - 1'b1;
            end else begin
                refreshCount <= refreshCount + 1'b1;
            end
        end
    end

endmodule

//--- hw/scrollingNumericDisplay.sv
// ==========================================================
// Scrolling decimal display top level
// load is taken only while ready is high; a load while busy
// is dropped. Display stays dark until the first conversion
// ==========================================================

`timescale 1ns/1ps

module scrollingNumericDisplay #(
    parameter int DWELL_FRAMES   = 150,
    parameter int REFRESH_CYCLES = 50_000
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [scrollPkg::NumberWidth-1:0] number,
    input  logic                              load,
    output logic                              ready,
    output logic [6:0]                        seg,
    output logic [3:0]                        an
);

    scrollPkg::bcdDigits digits;
    scrollPkg::asciiChar window0;
    scrollPkg::asciiChar window1;
    scrollPkg::asciiChar window2;
    scrollPkg::asciiChar window3;

    logic overflow;
    logic convDone;
    logic busy;
    logic loaded;
    logic frameEnd;

    // Converter drops start on its own while busy
    binToBcd converter (
        .clk      (clk),
        .reset    (reset),
        .start    (load),
        .number   (number),
        .digits   (digits),
        .overflow (overflow),
        .convDone (convDone),
        .busy     (busy)
    );

    scrollBuffer #(
        .DWELL_FRAMES (DWELL_FRAMES)
    ) buffer (
        .clk      (clk),
        .reset    (reset),
        .digits   (digits),
        .overflow (overflow),
        .convDone (convDone),
        .frameEnd (frameEnd),
        .loaded   (loaded),
        .window0  (window0),
        .window1  (window1),
        .window2  (window2),
        .window3  (window3)
    );

    segmentDriver #(
        .REFRESH_CYCLES (REFRESH_CYCLES)
    ) driver (
        .clk      (clk),
        .reset    (reset),
        .enable   (loaded),
        .window0  (window0),
        .window1  (window1),
        .window2  (window2),
        .window3  (window3),
        .seg      (seg),
        .an       (an),
        .frameEnd (frameEnd)
    );

    assign ready = ~busy;

endmodule

//--- bench/clockGen.sv
// ==========================================================
// Testbench clock with a 4 ns period
// reset is high for the first 4 cycles, released on a falling edge
// ==========================================================

`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- bench/scrollDisplayAsserts.sv
// ==========================================================
// Output protocol checks bound into the display top level
// assertFailures is read by the testbench at the end of the run
// ==========================================================

`timescale 1ns/1ps

module scrollDisplayAsserts (
    input logic       clk,
    input logic       reset,
    input logic       load,
    input logic       ready,
    input logic [6:0] seg,
    input logic [3:0] an
);

    int assertFailures = 0;

    // At most one digit lit
    property anodeOneHot;
        @(posedge clk) disable iff (reset) (an == 4'b1111) || $onehot(~an);
    endproperty

    // No segment driven while all digits are off
    property darkWhenOff;
        @(posedge clk) disable iff (reset) (an == 4'b1111) |-> (seg == 7'b1111111);
    endproperty

    property readyFalls;
        @(posedge clk) disable iff (reset) (load && ready) |=> !ready;
    endproperty

    assert property (anodeOneHot) else begin
        assertFailures++;
        $error("more than one anode is low: %b", an);
    end

    assert property (darkWhenOff) else begin
        assertFailures++;
        $error("segments lit while all anodes are off: %b", seg);
    end

    assert property (readyFalls) else begin
        assertFailures++;
        $error("ready stayed high after an accepted load");
    end

endmodule

bind scrollingNumericDisplay scrollDisplayAsserts outputChecks (
    .clk   (clk),
    .reset (reset),
    .load  (load),
    .ready (ready),
    .seg   (seg),
    .an    (an)
);

//--- bench/scrollDisplayTb.sv
// ==========================================================
// Testbench for the scrolling decimal display
// Runs with REFRESH_CYCLES 3 and DWELL_FRAMES 2 to keep frames short
// Windows are rebuilt from an and seg and compared with a model ring
// Frames that start before ready rises may mix two numbers and are skipped
// ==========================================================

`timescale 1ns/1ps

module scrollDisplayTb;

    localparam longint unsigned Limit = 64'd10_000_000_000;
    localparam int Timeout = 400;

    logic                              clk;
    logic                              reset;
    logic [scrollPkg::NumberWidth-1:0] number;
    logic                              load;
    logic                              ready;
    logic [6:0]                        seg;
    logic [3:0]                        an;

    int     errors = 0;
    int     checks = 0;
    longint cycle = 0;
    longint readyCycle = 0;

    // Frame monitor state, leftmost character in bits 31:24
    logic [31:0] curFrame = '0;
    logic [3:0]  seenMask = '0;
    logic [3:0]  prevAn = 4'b1111;
    longint      frameStart = 0;
    logic [31:0] frameQ[$];
    longint      startQ[$];

    clockGen clocks (
        .clk   (clk),
        .reset (reset)
    );

    scrollingNumericDisplay #(
        .DWELL_FRAMES   (2),
        .REFRESH_CYCLES (3)
    ) DUT (
        .clk    (clk),
        .reset  (reset),
        .number (number),
        .load   (load),
        .ready  (ready),
        .seg    (seg),
        .an     (an)
    );

    function automatic longint unsigned pow10(input int e);
        longint unsigned p;
        p = 1;
        for (int i = 0; i < e; i++) begin
            p = p * 10;
        end
        return p;
    endfunction

    function automatic int digitCount(input longint unsigned n);
        int d;
        d = 1;
        while (d < 10 && n >= pow10(d)) begin
            d++;
        end
        return d;
    endfunction

    function automatic int ringLength(input longint unsigned n);
        if (n >= Limit || digitCount(n) <= 4) begin
            return 4;
        end
        return digitCount(n) + 1;
    endfunction

    // Character idx of the expected ring
    function automatic logic [7:0] ringChar(input longint unsigned n, input int idx);
        int d;
        int pos;
        d = digitCount(n);
        if (n >= Limit) begin
            return (idx == 0) ? " " : (idx == 1) ? "E" : "r";
        end
        // Short numbers are padded on the left
        pos = (d <= 4) ? idx - (4 - d) : idx;
        if (pos < 0 || pos >= d) begin
            return " ";
        end
        return 8'h30 + 8'((n / pow10(d - 1 - pos)) % 10);
    endfunction

    function automatic logic [31:0] expectedWindow(input longint unsigned n, input int r);
        logic [31:0] w;
        int          len;
        len = ringLength(n);
        for (int k = 0; k < 4; k++) begin
            w[31 - 8*k -: 8] = ringChar(n, (r + k) % len);
        end
        return w;
    endfunction

    function automatic logic [7:0] segToChar(input logic [6:0] s);
        case (s)
            7'b0000001: return "0";
            7'b1001111: return "1";
            7'b0010010: return "2";
            7'b0000110: return "3";
            7'b1001100: return "4";
            7'b0100100: return "5";
            7'b0100000: return "6";
            7'b0001111: return "7";
            7'b0000000: return "8";
            7'b0000100: return "9";
            7'b0110000: return "E";
            7'b1111010: return "r";
            7'b1111111: return " ";
            default:    return "?";
        endcase
    endfunction

    function automatic longint unsigned randomInBand(input int band);
        longint unsigned wide;
        int              d;
        wide = {$urandom, $urandom};
        d = 5 + ($urandom % 6);
        case (band)
            0:       return wide % 10000;
            1:       return pow10(d - 1) + wide % (pow10(d) - pow10(d - 1));
            default: return Limit + wide % ((64'd1 << scrollPkg::NumberWidth) - Limit);
        endcase
    endfunction

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Frame capture on the falling edge, pushed when digit 0 ends
    always @(negedge clk) begin
        if (prevAn == 4'b1110 && an != 4'b1110 && seenMask == 4'b1111) begin
            frameQ.push_back(curFrame);
            startQ.push_back(frameStart);
            seenMask = '0;
        end
        if (an == 4'b0111 && prevAn != 4'b0111) begin
            seenMask = '0;
            frameStart = cycle;
        end
        for (int k = 0; k < 4; k++) begin
            if (an[k] == 1'b0) begin
                curFrame[k*8 +: 8] = segToChar(seg);
                seenMask[k] = 1'b1;
            end
        end
        prevAn = an;
    end

    task automatic waitReady(input logic level, output bit ok);
        ok = 0;
        for (int n = 0; n < Timeout && !ok; n++) begin
            @(negedge clk);
            ok = (ready === level);
        end
        if (!ok) begin
            errors++;
            $display("timeout: ready did not reach %0b within %0d cycles", level, Timeout);
        end else if (level) begin
            readyCycle = cycle;
        end
    endtask

    task automatic pulseLoad(input longint unsigned value);
        @(negedge clk);
        number = value[scrollPkg::NumberWidth-1:0];
        load = 1'b1;
        @(negedge clk);
        load = 1'b0;
    endtask

    // Next frame that started after the latest ready rise
    task automatic nextFrame(output logic [31:0] w, output bit ok);
        ok = 0;
        w = '0;
        for (int n = 0; n < Timeout && !ok; n++) begin
            @(negedge clk);
            while (startQ.size() > 0 && !ok) begin
                w = frameQ.pop_front();
                ok = (startQ.pop_front() > readyCycle);
            end
        end
        if (!ok) begin
            errors++;
            $display("timeout: no display frame within %0d cycles", Timeout);
        end
    endtask

    task automatic checkStatic(input string name, input longint unsigned value);
        logic [31:0] expected;
        logic [31:0] got;
        bit          ok;
        expected = expectedWindow(value, 0);
        ok = 1;
        for (int i = 0; i < 6 && ok; i++) begin
            nextFrame(got, ok);
            checks++;
            if (ok && got !== expected) begin
                errors++;
                $display("FAIL %s: expected \"%s\" got \"%s\"", name, expected, got);
            end
        end
    endtask

    // Distinct windows must follow the left rotations, wrapping once
    task automatic checkScroll(input string name, input longint unsigned value);
        logic [31:0] expected[$];
        logic [31:0] got;
        logic [31:0] last;
        bit          ok;
        int          len;
        int          idx;
        int          frames;
        len = ringLength(value);
        for (int r = 0; r <= len + 1; r++) begin
            if (expected.size() == 0 || expected[$] !== expectedWindow(value, r)) begin
                expected.push_back(expectedWindow(value, r));
            end
        end
        idx = 0;
        ok = 1;
        frames = 0;
        last = '0;
        while (ok && idx < expected.size() && frames < 8 * (len + 2)) begin
            nextFrame(got, ok);
            frames++;
            if (ok && (idx == 0 || got !== last)) begin
                checks++;
                if (got !== expected[idx]) begin
                    errors++;
                    $display("FAIL %s step %0d: expected \"%s\" got \"%s\"",
                             name, idx, expected[idx], got);
                end
                last = got;
                idx++;
            end
        end
        if (ok && idx < expected.size()) begin
            errors++;
            $display("%s: display showed only %0d of %0d scroll windows",
                     name, idx, expected.size());
        end
    endtask

    task automatic runCase(input string name, input longint unsigned value);
        bit ok;
        bit low;
        waitReady(1'b1, ok);
        pulseLoad(value);
        waitReady(1'b0, low);
        waitReady(1'b1, ok);
        if (ok && low) begin
            if (ringLength(value) > 4) begin
                checkScroll(name, value);
            end else begin
                checkStatic(name, value);
            end
        end
    endtask

    initial begin
        bit              ok;
        logic [31:0]     dummy;
        longint unsigned heldValue;
        number = '0;
        load = 1'b0;
        void'($urandom(3533));

        ok = 0;
        for (int i = 0; i < Timeout && !ok; i++) begin
            @(negedge clk);
            ok = (reset === 1'b0);
        end
        if (!ok) begin
            errors++;
            $display("timeout: reset was never released");
        end

        // Display stays dark until the first conversion
        for (int i = 0; i < 40; i++) begin
            @(negedge clk);
            checks++;
            if (ready !== 1'b1 || an !== 4'hF || seg !== 7'h7F) begin
                errors++;
                $display("FAIL idle: expected ready 1 an f seg 7f, got ready %b an %h seg %h",
                         ready, an, seg);
            end
        end

        runCase("zero", 0);
        runCase("maxValue", 64'd9_999_999_999);
        runCase("limit", Limit);
        for (int i = 0; i < 9; i++) begin
            runCase($sformatf("random%0d", i), randomInBand(i % 3));
        end

        // Second load arrives while the converter is busy
        heldValue = randomInBand(0);
        waitReady(1'b1, ok);
        pulseLoad(heldValue);
        waitReady(1'b0, ok);
        pulseLoad(Limit + 5);
        waitReady(1'b1, ok);
        checkStatic("ignoredLoad", heldValue);

        // Interrupt a scroll part way through
        runCase("scrollFirst", randomInBand(1));
        for (int i = 0; i < 5; i++) begin
            nextFrame(dummy, ok);
        end
        runCase("restart", randomInBand(1));

        errors += DUT.outputChecks.assertFailures;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, DUT.outputChecks.assertFailures);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- scrollDisplay.f
hw/scrollPkg.sv
hw/binToBcd.sv
hw/scrollBuffer.sv
hw/segmentDriver.sv
hw/scrollingNumericDisplay.sv
bench/clockGen.sv
bench/scrollDisplayAsserts.sv
bench/scrollDisplayTb.sv
